/* Makefile */
# Verilator build and run for the shared-memory testbench.

VERILATOR ?= verilator
TOP       ?= mem_share_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

PASS_MSG  := Finished with no errors
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  mem_share_pkg::port_mask_t req,
  input  mem_share_pkg::mem_req_t   cmd [mem_share_pkg::N_PORTS],
  output mem_share_pkg::port_mask_t gnt,
  output logic                      mem_en,
  output mem_share_pkg::mem_req_t   mem_cmd,
  output mem_share_pkg::port_mask_t winner
);

  import mem_share_pkg::*;

  // Width of one command as a flat vector.
  localparam int CMD_W = $bits(mem_req_t);

  // The last winner resets to the highest port.
  // Port 0 then has first priority.
  localparam port_mask_t LAST_WIN_RST = port_mask_t'(1) << (N_PORTS - 1);

  // One-hot record of the peer granted most recently.
  port_mask_t last_win;

  // Ports strictly above the last winner.
  port_mask_t upper_mask;

  // Requests that fall in the upper window.
  port_mask_t masked_req;

  // Lowest requester above the last winner.
  port_mask_t pick_masked;

  // Lowest requester overall for wrap-around.
  port_mask_t pick_all;

  // Selected grant before it goes out.
  port_mask_t grant;

  // OR of the commands qualified by the grant.
  logic [CMD_W-1:0] cmd_or;

  // Bits at and below the last winner are cleared.
  // last_win - 1 fills the bits below the one-hot bit.
  assign upper_mask = ~(last_win | (last_win - port_mask_t'(1)));
  assign masked_req = req & upper_mask;

  // First pass looks only above the last winner.
  onehot_priority #(
    .WIDTH (N_PORTS)
  ) u_pick_masked (
    .in  (masked_req),
    .out (pick_masked)
  );

  // Second pass looks at every request.
  onehot_priority #(
    .WIDTH (N_PORTS)
  ) u_pick_all (
    .in  (req),
    .out (pick_all)
  );

  // Wrap to the full set when nobody above the last winner is asking.
  assign grant  = (|masked_req) ? pick_masked : pick_all;
  assign gnt    = grant;
  assign winner = grant;
  assign mem_en = |grant;

  // One-hot multiplexer.
  // At most one term is non-zero, so an OR tree does the selection.
  always_comb begin
    cmd_or = '0;
    for (int p = 0; p < N_PORTS; p++) begin
      cmd_or = cmd_or | ({CMD_W{grant[p]}} & cmd[p]);
    end
  end

  assign mem_cmd = mem_req_t'(cmd_or);

  // Remember who won.
  // Only moves on edges that carry an access.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_win <= LAST_WIN_RST;
    end else if (mem_en) begin
      last_win <= grant;
    end
  end

endmodule

/* hw/mem_share_pkg.sv */
package mem_share_pkg;

  // Number of peers that share the memory.
  localparam int N_PORTS = 3;

  // Word address width.
  localparam int ADDR_W = 6;

  // Word width.
  localparam int DATA_W = 16;

  // One memory word per address.
  localparam int DEPTH = 64;

  // One bit per peer.
  // Used for request, grant and winner bitmaps.
  typedef logic [N_PORTS-1:0] port_mask_t;

  // Access opcode.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // Command presented by a peer while its request is high.
  typedef struct packed {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } mem_req_t;

  // Read response strobed for one cycle on the winning port.
  typedef struct packed {
    logic                valid;
    logic [DATA_W-1:0]   rdata;
  } mem_rsp_t;

endpackage

/* hw/mem_share_top.sv */
`timescale 1ns/1ps

module mem_share_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  mem_share_pkg::port_mask_t req,
  input  mem_share_pkg::mem_req_t   cmd [mem_share_pkg::N_PORTS],
  output mem_share_pkg::port_mask_t gnt,
  output mem_share_pkg::mem_rsp_t   rsp [mem_share_pkg::N_PORTS]
);

  import mem_share_pkg::*;

  // Access strobe from the arbiter to the memory.
  logic mem_en;

  // Command of the granted peer.
  mem_req_t mem_cmd;

  // One-hot winner that lets the read data find its way back.
  port_mask_t winner;

  // Round-robin arbitration.
  // Grant is combinational from req.
  bus_arbiter u_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .cmd     (cmd),
    .gnt     (gnt),
    .mem_en  (mem_en),
    .mem_cmd (mem_cmd),
    .winner  (winner)
  );

  // Single-port memory.
  // Writes land at the grant edge; reads answer one cycle later.
  shared_sram u_sram (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_en  (mem_en),
    .mem_cmd (mem_cmd),
    .winner  (winner),
    .rsp     (rsp)
  );

endmodule

/* hw/onehot_priority.sv */
`timescale 1ns/1ps

module onehot_priority #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] in,
  output logic [WIDTH-1:0] out
);

  // Set once a request has been seen lower down the scan.
  logic deny;

  // Scan from bit 0 upward.
  // The first set bit passes and every bit above it is denied.
  // So 'b011100 gives 'b000100.
  always_comb begin
    deny = 1'b0;
    out  = '0;
    for (int i = 0; i < WIDTH; i++) begin
      out[i] = in[i] && !deny;
      deny   = deny || in[i];
    end
  end

endmodule

/* hw/shared_sram.sv */
`timescale 1ns/1ps

module shared_sram (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      mem_en,
  input  mem_share_pkg::mem_req_t   mem_cmd,
  input  mem_share_pkg::port_mask_t winner,
  output mem_share_pkg::mem_rsp_t   rsp [mem_share_pkg::N_PORTS]
);

  import mem_share_pkg::*;

  // Storage array.
  logic [DATA_W-1:0] mem [DEPTH];

  // Decoded access strobes for this cycle.
  logic wr_en;
  logic rd_en;

  // Read word captured at the grant edge.
  logic [DATA_W-1:0] rd_data;

  // A read was accepted on the previous edge.
  logic rd_valid;

  // Peer that issued that read.
  port_mask_t rd_winner;

  assign wr_en = mem_en && (mem_cmd.op == OP_WRITE);
  assign rd_en = mem_en && (mem_cmd.op == OP_READ);

  // Write port.
  // The store lands at the edge that closes the grant cycle.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[mem_cmd.addr] <= mem_cmd.wdata;
    end
  end

  // Registered read port.
  // Only one access per edge, so a read never overlaps a write.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[mem_cmd.addr];
    end
  end

  // Response control.
  // Valid is a single-cycle strobe after each read grant.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid  <= 1'b0;
      rd_winner <= '0;
    end else begin
      rd_valid <= rd_en;
      if (rd_en) begin
        rd_winner <= winner;
      end
    end
  end

  // Route the response to the peer that won the read.
  // Other ports see valid low and zero data.
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      rsp[p].valid = rd_valid && rd_winner[p];
      rsp[p].rdata = rd_winner[p] ? rd_data : '0;
    end
  end

endmodule

/* verification/mem_share_tb.sv */
`timescale 1ns/1ps

module mem_share_tb;

  import mem_share_pkg::*;

  // Clock period in ns and run lengths in cycles.
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 5;
  localparam int FILL_CYCLES     = DEPTH + 4;
  localparam int RANDOM_CYCLES   = 400;
  localparam int FULL_CYCLES     = 60;
  localparam int IDLE_CYCLES     = 20;
  localparam int MARGIN_CYCLES   = 100;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + FILL_CYCLES + RANDOM_CYCLES
                                 + FULL_CYCLES + IDLE_CYCLES + MARGIN_CYCLES;
  localparam int SEED            = 37;

  // Test phases stepped by the main process.
  typedef enum logic [2:0] {
    PH_RESET,
    PH_FILL,
    PH_RANDOM,
    PH_FULL,
    PH_IDLE
  } phase_e;

  // DUT ports start from known values.
  logic       clk   = 1'b0;
  logic       rst_n = 1'b0;
  port_mask_t req   = '0;
  mem_req_t   cmd [N_PORTS] = '{default: '0};
  port_mask_t gnt;
  mem_rsp_t   rsp [N_PORTS];

  phase_e phase = PH_RESET;

  // Fill walker for port 0.
  int   fill_addr = 0;
  logic fill_done = 1'b0;

  // Reference model state.
  logic [DATA_W-1:0] ref_mem [DEPTH];
  int                rr_last;
  port_mask_t        exp_gnt;
  port_mask_t        last_exp_gnt;
  port_mask_t        exp_valid;
  logic [DATA_W-1:0] exp_data;

  // Cycles each port has waited with req high and no grant.
  int wait_cnt [N_PORTS];

  // Valid bits of rsp gathered into one bitmap.
  port_mask_t rsp_valid;

  int error_count = 0;

  mem_share_top uut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .cmd   (cmd),
    .gnt   (gnt),
    .rsp   (rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Reports a wrong value and stops the run.
  task automatic fail_value(input string name, input logic [31:0] exp_val,
                            input logic [31:0] got_val);
    error_count++;
    $display("error at %0t ns: %s expected 'h%0h, got 'h%0h", $time, name, exp_val, got_val);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // Write of a known word made from every address bit.
  function automatic mem_req_t fill_cmd(input int a);
    mem_req_t          c;
    logic [ADDR_W-1:0] a6;
    a6      = a[ADDR_W-1:0];
    c.op    = OP_WRITE;
    c.addr  = a6;
    c.wdata = {2'b10, a6, 2'b01, ~a6};
    return c;
  endfunction

  // Random command over a narrow address window so that accesses collide.
  function automatic mem_req_t rand_cmd();
    mem_req_t    c;
    logic [31:0] r;
    r       = $urandom;
    c.op    = mem_op_e'(r[8]);
    c.addr  = {3'b000, r[2:0]};
    c.wdata = r[31:16];
    return c;
  endfunction

  // First requester upward from last+1, wrapping around.
  function automatic port_mask_t rr_pick(input port_mask_t r, input int last);
    port_mask_t pick;
    int         idx;
    pick = '0;
    for (int k = 1; k <= N_PORTS; k++) begin
      idx = (last + k) % N_PORTS;
      if (r[idx] && (pick == '0)) begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  // Grant bitmap turned one place upward.
  function automatic port_mask_t rotl(input port_mask_t m);
    return {m[N_PORTS-2:0], m[N_PORTS-1]};
  endfunction

  always_comb begin
    exp_gnt = rr_pick(req, rr_last);
  end

  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      rsp_valid[p] = rsp[p].valid;
    end
  end

  // Peers.
  // A command stays put until granted, then the next one is chosen.
  always @(posedge clk) begin : drive_peers
    logic [31:0] r;
    case (phase)
      PH_FILL: begin
        if (!fill_done) begin
          if (req[0] && gnt[0]) begin
            if (fill_addr == DEPTH - 1) begin
              req[0]    <= 1'b0;
              fill_done <= 1'b1;
            end else begin
              fill_addr <= fill_addr + 1;
              cmd[0]    <= fill_cmd(fill_addr + 1);
            end
          end else begin
            req[0] <= 1'b1;
            cmd[0] <= fill_cmd(fill_addr);
          end
        end
      end
      PH_RANDOM, PH_FULL: begin
        for (int p = 0; p < N_PORTS; p++) begin
          if (!req[p] || gnt[p]) begin
            r = $urandom;
            // Busy three cycles in four in the random phase and always in the full phase.
            req[p] <= (phase == PH_FULL) || (r[1:0] != 2'b00);
            cmd[p] <= rand_cmd();
          end
        end
      end
      PH_IDLE: begin
        req <= '0;
      end
      default: begin
      end
    endcase
  end

  // Arbiter model and expected read responses.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_last      <= N_PORTS - 1;
      last_exp_gnt <= '0;
      exp_valid    <= '0;
      exp_data     <= '0;
    end else begin
      last_exp_gnt <= exp_gnt;
      exp_valid    <= '0;
      for (int p = 0; p < N_PORTS; p++) begin
        if (exp_gnt[p]) begin
          rr_last <= p;
          if (cmd[p].op == OP_READ) begin
            exp_valid[p] <= 1'b1;
            exp_data     <= ref_mem[cmd[p].addr];
          end
        end
      end
    end
  end

  // Memory model updated at each accepted write.
  always @(posedge clk) begin
    for (int p = 0; p < N_PORTS; p++) begin
      if (rst_n && exp_gnt[p] && (cmd[p].op == OP_WRITE)) begin
        ref_mem[cmd[p].addr] <= cmd[p].wdata;
      end
    end
  end

  // Waiting time per port.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < N_PORTS; p++) begin
        wait_cnt[p] <= 0;
      end
    end else begin
      for (int p = 0; p < N_PORTS; p++) begin
        wait_cnt[p] <= (req[p] && !gnt[p]) ? wait_cnt[p] + 1 : 0;
      end
    end
  end

  // Grant is zero or one-hot and only goes to a requester.
  a_gnt_legal: assert property (@(posedge clk)
    $onehot0(gnt) && ((gnt & ~req) == '0))
    else fail_value("gnt", 32'($sampled(exp_gnt)), 32'($sampled(gnt)));

  // Grant follows the rotating priority.
  a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
    gnt == exp_gnt)
    else fail_value("gnt", 32'($sampled(exp_gnt)), 32'($sampled(gnt)));

  // With all ports busy the grant steps 0, 1, 2, 0.
  a_full_rotate: assert property (@(posedge clk) disable iff (!rst_n)
    ((&req) && (&$past(req))) |-> (gnt == rotl(last_exp_gnt)))
    else fail_value("gnt", 32'(rotl($sampled(last_exp_gnt))), 32'($sampled(gnt)));

  // Valid only on the port that won a read one cycle earlier.
  a_rsp_timing: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid == exp_valid)
    else fail_value("rsp.valid", 32'($sampled(exp_valid)), 32'($sampled(rsp_valid)));

  // Quiet while reset is held.
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> ((gnt == '0) && (rsp_valid == '0)))
    else fail_value("{gnt, rsp.valid}", 32'(0), 32'({$sampled(gnt), $sampled(rsp_valid)}));

  // Two idle cycles leave nothing granted and nothing to answer.
  a_idle_quiet: assert property (@(posedge clk)
    ((req == '0) && ($past(req) == '0)) |-> ((gnt == '0) && (rsp_valid == '0)))
    else fail_value("{gnt, rsp.valid}", 32'(0), 32'({$sampled(gnt), $sampled(rsp_valid)}));

  for (genvar p = 0; p < N_PORTS; p++) begin : g_port_checks
    // A waiting port is served within N_PORTS cycles.
    a_no_starve: assert property (@(posedge clk) disable iff (!rst_n)
      wait_cnt[p] < N_PORTS)
      else fail_value($sformatf("wait_cnt[%0d]", p), 32'(N_PORTS - 1),
                      32'($sampled(wait_cnt[p])));

    // Read data matches the model word.
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid[p] |-> (rsp[p].rdata == exp_data))
      else fail_value($sformatf("rsp[%0d].rdata", p), 32'($sampled(exp_data)),
                      32'($sampled(rsp[p].rdata)));
  end

  // Watchdog.
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("The run timed out before all test phases had finished.");
    $display("Finished with errors");
    $fatal(1);
  end

  // Phase sequence.
  initial begin
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    phase <= PH_FILL;
    // Port 0 writes every word before any read.
    wait (fill_done);
    @(posedge clk);
    phase <= PH_RANDOM;
    repeat (RANDOM_CYCLES) @(posedge clk);
    phase <= PH_FULL;
    repeat (FULL_CYCLES) @(posedge clk);
    phase <= PH_IDLE;
    repeat (IDLE_CYCLES) @(posedge clk);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* vlog.f */
hw/mem_share_pkg.sv
hw/onehot_priority.sv
hw/bus_arbiter.sv
hw/shared_sram.sv
hw/mem_share_top.sv
verification/mem_share_tb.sv
